// File: sim.f
soc_pkg.sv
bus_decoder.sv
ram_port.sv
sd_sector_buffer.sv
char_io.sv
bus_fabric.sv
soc_top.sv
tb_soc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, then scan the log for the result
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc -f sim.f -o tb_soc \
    && ./obj_dir/tb_soc > sim.log 2>&1 \
    || echo "build or simulation ended early" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1

// File: tb_soc.sv
`timescale 1ns/1ps

module tb_soc
    import soc_pkg::*;
();

    // memory map handed to the DUT
    localparam logic [xlen-1:0] ram_base       = 64'h0000_1000;
    localparam logic [xlen-1:0] key_addr       = 64'h1000_0000;
    localparam logic [xlen-1:0] uart_addr      = 64'h1000_0008;
    localparam logic [xlen-1:0] sdc_addr_reg   = 64'h1000_0010;
    localparam logic [xlen-1:0] sdc_read_reg   = 64'h1000_0018;
    localparam logic [xlen-1:0] sdc_ready_reg  = 64'h1000_0020;
    localparam logic [xlen-1:0] sdc_avail_reg  = 64'h1000_0028;
    localparam logic [xlen-1:0] sdc_cache_base = 64'h1000_1000;
    localparam logic [xlen-1:0] hole_addr      = 64'h2000_0000;  // unmapped
    localparam int              timeout_cycles = 20;

    logic            CLOCK_50, KEY0;
    logic [xlen-1:0] bus_address, bus_write_data, bus_read_data;
    logic            bus_write_enable, bus_read_enable, bus_read_done, bus_write_done;
    load_e           bus_read_type;
    store_e          bus_write_type;
    logic [3:0]      interrupt_vector;
    logic            interrupt_ack, irq_led, key_pressed, uart_write;
    logic [7:0]      key_ascii, sd_dout, uart_data;
    logic            sd_byte_available, sd_ready, sd_rd_start, sd_cache_available;
    logic [31:0]     sd_addr;

    // stimulus table with one bus access per row
    string           tab_name  [80];
    logic            tab_write [80];
    logic [xlen-1:0] tab_addr  [80];
    logic [2:0]      tab_type  [80];
    logic [xlen-1:0] tab_data  [80];
    logic [xlen-1:0] tab_exp   [80];
    logic [7:0]      tab_lat   [80];  // edges from enable to done
    int              n_entries;

    word_t           model [16];             // expected ram words
    logic [15:0]     lfsr;
    logic [7:0]      sector [sector_bytes];  // bytes fed to the sd buffer
    int              rd_start_pulses, uart_pulses;
    logic [7:0]      uart_seen;

    soc_top #(
        .ram_base(ram_base), .key_addr(key_addr), .uart_addr(uart_addr),
        .sdc_addr_reg(sdc_addr_reg), .sdc_read_reg(sdc_read_reg),
        .sdc_ready_reg(sdc_ready_reg), .sdc_avail_reg(sdc_avail_reg),
        .sdc_cache_base(sdc_cache_base)
    ) dut_i (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    // pulse monitors sample mid-cycle when the flops have settled
    always @(negedge CLOCK_50) begin
        if (sd_rd_start)
            rd_start_pulses++;
        if (uart_write) begin
            uart_pulses++;
            uart_seen = uart_data;
        end
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [xlen-1:0] lfsr_bits(input int n);
        logic [xlen-1:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[xlen-2:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;
        end
        return val;
    endfunction

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [xlen-1:0] exp, act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic step_cycles(input int n);
        repeat (n) @(posedge CLOCK_50);
        #0.5;  // drive point after the edge
    endtask

    // counts edges until the done level is back and checks the count
    task automatic wait_done(input string name, input logic wr, input logic [7:0] exp_lat);
        logic [7:0] lat;
        lat = 8'd0;
        while (!(wr ? bus_write_done : bus_read_done)) begin
            step_cycles(1);
            lat++;
            if (lat > timeout_cycles) begin
                $display("timeout: %s never completed on the bus", name);
                abort_run();
            end
        end
        check_byte({name, " latency"}, exp_lat, lat);
    endtask

    task automatic do_read(input string name, input logic [xlen-1:0] addr,
                           input logic [2:0] typ, input logic [xlen-1:0] exp,
                           input logic [7:0] exp_lat);
        bus_address     = addr;
        bus_read_type   = load_e'(typ);
        bus_read_enable = 1'b1;
        step_cycles(1);
        bus_read_enable = 1'b0;  // single cycle request
        wait_done(name, 1'b0, exp_lat);
        check_data(name, exp, bus_read_data);
    endtask

    task automatic do_write(input string name, input logic [xlen-1:0] addr,
                            input logic [2:0] typ, input logic [xlen-1:0] data,
                            input logic [7:0] exp_lat);
        bus_address      = addr;
        bus_write_type   = store_e'(typ);
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        step_cycles(1);
        bus_write_enable = 1'b0;
        wait_done(name, 1'b1, exp_lat);
    endtask

    task automatic add_entry(input string name, input logic wr, input logic [xlen-1:0] addr,
                             input logic [2:0] typ, input logic [xlen-1:0] data, exp,
                             input logic [7:0] lat);
        tab_name[n_entries]  = name;
        tab_write[n_entries] = wr;
        tab_addr[n_entries]  = addr;
        tab_type[n_entries]  = typ;
        tab_data[n_entries]  = data;
        tab_exp[n_entries]   = exp;
        tab_lat[n_entries]   = lat;
        n_entries++;
    endtask

    // store row where the model keeps only the addressed lanes
    task automatic ram_store(input int idx, input int off, input store_e st,
                             input logic [xlen-1:0] data);
        case (st)
            sb: model[idx][8 * off +: 8] = data[7:0];
            sh: model[idx][16 * (off / 2) +: 16] = data[15:0];
            sw: model[idx] = data[31:0];
            default: begin
                model[idx]     = data[31:0];   // low word first
                model[idx + 1] = data[63:32];
            end
        endcase
        add_entry($sformatf("%s w%0d o%0d", st.name(), idx, off), 1'b1,
                  ram_base + 4 * idx + off, st, data, '0, (st == sd) ? 8'd2 : 8'd1);
    endtask

    // load row with sub-word results shifted down and zero filled
    task automatic ram_load(input int idx, input int off, input load_e lt);
        logic [xlen-1:0] exp;
        if (lt == ld)
            exp = {model[idx + 1], model[idx]};
        else
            exp = {32'd0, model[idx] >> (8 * off)};
        add_entry($sformatf("%s w%0d o%0d", lt.name(), idx, off), 1'b0,
                  ram_base + 4 * idx + off, lt, '0, exp, (lt == ld) ? 8'd2 : 8'd1);
    endtask

    initial begin
        logic [xlen-1:0] val;
        int              pick;
        int              wait_cnt;
        KEY0 = 1'b0;
        bus_address = '0;
        bus_write_data = '0;
        bus_write_enable = 1'b0;
        bus_read_enable = 1'b0;
        bus_read_type = lw;
        bus_write_type = sw;
        interrupt_ack = 1'b0;
        key_pressed = 1'b0;
        key_ascii = 8'h41;
        sd_dout = 8'd0;
        sd_byte_available = 1'b0;
        sd_ready = 1'b1;
        lfsr = 16'd35706;
        n_entries = 0;
        rd_start_pulses = 0;
        uart_pulses = 0;

        // sub-word stores then every legal load offset
        for (int w = 0; w < 4; w++) begin
            ram_store(w, 0, sw, lfsr_bits(32));
            ram_store(w, (w % 2) * 2, sh, lfsr_bits(16));
            ram_store(w, w, sb, lfsr_bits(8));
            ram_load(w, 0, lw);
            ram_load(w, 0, lh);
            ram_load(w, 2, lh);
            for (int o = 0; o < 4; o++)
                ram_load(w, o, lb);
            ram_load(w, w, lbu);
        end
        ram_store(6, 0, sw, lfsr_bits(32));  // neighbours of the double
        ram_store(9, 0, sw, lfsr_bits(32));
        ram_store(7, 0, sd, lfsr_bits(64));
        ram_load(7, 0, ld);
        ram_load(6, 0, lw);
        ram_load(8, 0, lw);                  // high half of the double
        ram_load(9, 0, lw);
        add_entry("key read", 1'b0, key_addr, lbu, '0, 64'h41, 8'd1);
        add_entry("sd avail idle", 1'b0, sdc_avail_reg, lw, '0, 64'd0, 8'd1);
        add_entry("sd ready read", 1'b0, sdc_ready_reg, lw, '0, 64'd1, 8'd1);
        add_entry("unmapped read", 1'b0, hole_addr, ld, '0, 64'd0, 8'd1);
        add_entry("unmapped write", 1'b1, hole_addr + 8, sd, lfsr_bits(64), '0, 8'd1);

        step_cycles(4);
        KEY0 = 1'b1;
        check_bit("read done idle", 1'b1, bus_read_done);
        check_bit("write done idle", 1'b1, bus_write_done);
        check_bit("irq_led idle", 1'b0, irq_led);
        check_bit("cache avail idle", 1'b0, sd_cache_available);

        for (int i = 0; i < n_entries; i++) begin
            if (tab_write[i])
                do_write(tab_name[i], tab_addr[i], tab_type[i], tab_data[i], tab_lat[i]);
            else
                do_read(tab_name[i], tab_addr[i], tab_type[i], tab_exp[i], tab_lat[i]);
        end

        // sd registers
        val = lfsr_bits(64);
        do_write("sd addr write", sdc_addr_reg, sw, val, 8'd1);
        check_data("sd_addr", {32'd0, val[31:0]}, {32'd0, sd_addr});
        do_write("sd read trigger", sdc_read_reg, sw, 64'd1, 8'd1);
        step_cycles(3);
        check_byte("sd_rd_start pulses", 8'd1, 8'(rd_start_pulses));

        // one sector with the strobe high then low per byte
        for (int i = 0; i < sector_bytes; i++) begin
            sector[i] = 8'(lfsr_bits(8));
            sd_dout = sector[i];
            sd_byte_available = 1'b1;
            step_cycles(1);
            sd_byte_available = 1'b0;
            step_cycles(1);
        end
        wait_cnt = 0;
        while (!sd_cache_available) begin
            step_cycles(1);
            wait_cnt++;
            if (wait_cnt > timeout_cycles) begin
                $display("timeout: cache available flag never set after a full sector");
                abort_run();
            end
        end
        do_read("sd avail full", sdc_avail_reg, lw, 64'd1, 8'd1);
        for (int k = 0; k < 6; k++) begin
            pick = (k == 0) ? 0 : (k == 1) ? sector_bytes - 1 : int'(lfsr_bits(9));
            do_read($sformatf("cache byte %0d", pick), sdc_cache_base + pick, lbu,
                    {56'd0, sector[pick]}, 8'd1);
        end
        sd_ready = 1'b0;
        step_cycles(2);
        do_read("sd ready low", sdc_ready_reg, lw, 64'd0, 8'd1);

        // keyboard interrupt set and ack
        key_ascii = 8'h5A;
        key_pressed = 1'b1;
        step_cycles(1);
        key_pressed = 1'b0;
        check_byte("irq vector set", 8'd1, {4'd0, interrupt_vector});
        check_bit("irq_led set", 1'b1, irq_led);
        do_read("key read new", key_addr, lbu, 64'h5A, 8'd1);
        interrupt_ack = 1'b1;
        step_cycles(1);
        interrupt_ack = 1'b0;
        check_byte("irq vector clear", 8'd0, {4'd0, interrupt_vector});
        check_bit("irq_led clear", 1'b0, irq_led);

        // uart strobe carries the low byte only
        val = lfsr_bits(64);
        do_write("uart write", uart_addr, sb, val, 8'd1);
        step_cycles(3);
        check_byte("uart pulses", 8'd1, 8'(uart_pulses));
        check_byte("uart data", val[7:0], uart_seen);

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: soc_top.sv
`timescale 1ns/1ps

module soc_top import soc_pkg::*; #(
    parameter logic [xlen-1:0] ram_base       = 64'h0000_1000,
    parameter int              ram_words      = 1024,
    parameter logic [xlen-1:0] key_addr       = 64'h1000_0000,
    parameter logic [xlen-1:0] uart_addr      = 64'h1000_0008,
    parameter logic [xlen-1:0] sdc_addr_reg   = 64'h1000_0010,
    parameter logic [xlen-1:0] sdc_read_reg   = 64'h1000_0018,
    parameter logic [xlen-1:0] sdc_ready_reg  = 64'h1000_0020,
    parameter logic [xlen-1:0] sdc_avail_reg  = 64'h1000_0028,
    parameter logic [xlen-1:0] sdc_cache_base = 64'h1000_1000
) (
    input  logic            CLOCK_50,
    input  logic            KEY0,
    input  logic [xlen-1:0] bus_address,
    input  logic [xlen-1:0] bus_write_data,
    input  logic            bus_write_enable,
    input  logic            bus_read_enable,
    input  load_e           bus_read_type,
    input  store_e          bus_write_type,
    output logic [xlen-1:0] bus_read_data,
    output logic            bus_read_done,
    output logic            bus_write_done,
    output logic [3:0]      interrupt_vector,
    input  logic            interrupt_ack,
    output logic            irq_led,
    input  logic            key_pressed,
    input  logic [7:0]      key_ascii,
    input  logic [7:0]      sd_dout,
    input  logic            sd_byte_available,
    input  logic            sd_ready,
    output logic            sd_rd_start,
    output logic [31:0]     sd_addr,
    output logic            sd_cache_available,
    output logic            uart_write,
    output logic [7:0]      uart_data
);

    target_e                      target;
    logic [$clog2(ram_words)-1:0] ram_index;
    logic [1:0]                   byte_offset;
    logic [8:0]                   cache_index;
    logic [xlen-1:0]              ram_read_data;
    logic                         ram_finish, ram_read_start, ram_write_start;
    logic                         addr_write, read_trigger, uart_hit;
    logic [7:0]                   key_byte, cache_byte;
    logic                         ready_bit;

    bus_decoder #(
        .ram_base(ram_base), .ram_words(ram_words), .key_addr(key_addr),
        .uart_addr(uart_addr), .sdc_addr_reg(sdc_addr_reg),
        .sdc_read_reg(sdc_read_reg), .sdc_ready_reg(sdc_ready_reg),
        .sdc_avail_reg(sdc_avail_reg), .sdc_cache_base(sdc_cache_base)
    ) decoder_i (
        .bus_address, .target, .ram_index, .byte_offset, .cache_index
    );

    ram_port #(.ram_words(ram_words)) ram_i (
        .CLOCK_50, .KEY0, .read_start(ram_read_start), .write_start(ram_write_start),
        .load_type(bus_read_type), .store_type(bus_write_type), .ram_index,
        .byte_offset, .write_data(bus_write_data), .read_data(ram_read_data),
        .finish(ram_finish)
    );

    sd_sector_buffer sdc_i (
        .CLOCK_50, .KEY0, .sd_dout, .sd_byte_available, .sd_ready, .addr_write,
        .read_trigger, .write_data(bus_write_data[31:0]), .cache_index, .sd_addr,
        .sd_rd_start, .sd_cache_available, .cache_byte, .ready_bit
    );

    char_io char_i (
        .CLOCK_50, .KEY0, .key_pressed, .key_ascii, .interrupt_ack, .uart_hit,
        .write_data(bus_write_data), .uart_write, .uart_data, .interrupt_vector,
        .irq_led, .key_byte
    );

    bus_fabric fabric_i (
        .CLOCK_50, .KEY0, .bus_read_enable, .bus_write_enable, .target, .ram_finish,
        .ram_read_data, .key_byte, .cache_byte, .ready_bit,
        .avail_bit(sd_cache_available), .bus_read_done, .bus_write_done, .bus_read_data,
        .ram_read_start, .ram_write_start, .addr_write, .read_trigger, .uart_hit
    );

endmodule

// File: bus_fabric.sv
`timescale 1ns/1ps

module bus_fabric import soc_pkg::*; (
    input  logic            CLOCK_50,
    input  logic            KEY0,
    input  logic            bus_read_enable,
    input  logic            bus_write_enable,
    input  target_e         target,
    input  logic            ram_finish,
    input  logic [xlen-1:0] ram_read_data,
    input  logic [7:0]      key_byte,
    input  logic [7:0]      cache_byte,
    input  logic            ready_bit,
    input  logic            avail_bit,
    output logic            bus_read_done,
    output logic            bus_write_done,
    output logic [xlen-1:0] bus_read_data,
    output logic            ram_read_start,
    output logic            ram_write_start,
    output logic            addr_write,
    output logic            read_trigger,
    output logic            uart_hit
);

    logic            rd_local;   // register or unmapped read pending
    logic            wr_local;   // register or unmapped write pending
    logic            read_finish;
    logic            write_finish;
    logic [xlen-1:0] sel_data;

    // ram starts with the enable itself
    assign ram_read_start  = bus_read_enable && target == t_ram;
    assign ram_write_start = bus_write_enable && target == t_ram;

    // register strobes in the cycle after the enable
    assign addr_write   = wr_local && target == t_sdc_addr;
    assign read_trigger = wr_local && target == t_sdc_read;
    assign uart_hit     = wr_local && target == t_uart;

    assign read_finish  = !bus_read_done && (rd_local || ram_finish);
    assign write_finish = !bus_write_done && (wr_local || ram_finish);

    always_comb begin
        case (target)
            t_ram:       sel_data = ram_read_data;
            t_key:       sel_data = {56'd0, key_byte};
            t_sdc_cache: sel_data = {56'd0, cache_byte};  // one byte per load
            t_sdc_ready: sel_data = {63'd0, ready_bit};
            t_sdc_avail: sel_data = {63'd0, avail_bit};
            default:     sel_data = '0;  // unmapped and write-only regs
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_local       <= 1'b0;
            wr_local       <= 1'b0;
            bus_read_done  <= 1'b1;  // idle high
            bus_write_done <= 1'b1;
        end else begin
            rd_local <= bus_read_enable && target != t_ram;
            wr_local <= bus_write_enable && target != t_ram;
            if (bus_read_enable)   bus_read_done <= 1'b0;
            else if (read_finish)  bus_read_done <= 1'b1;
            if (bus_write_enable)  bus_write_done <= 1'b0;
            else if (write_finish) bus_write_done <= 1'b1;
        end
    end

    // held until the next read completes
    always_ff @(posedge CLOCK_50) begin
        if (read_finish)
            bus_read_data <= sel_data;
    end

    a_one_in_flight: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (bus_read_enable || bus_write_enable) |-> (bus_read_done && bus_write_done));

endmodule

// File: char_io.sv
`timescale 1ns/1ps

module char_io import soc_pkg::*; (
    input  logic            CLOCK_50,
    input  logic            KEY0,
    input  logic            key_pressed,
    input  logic [7:0]      key_ascii,
    input  logic            interrupt_ack,
    input  logic            uart_hit,
    input  logic [xlen-1:0] write_data,
    output logic            uart_write,
    output logic [7:0]      uart_data,
    output logic [3:0]      interrupt_vector,
    output logic            irq_led,
    output logic [7:0]      key_byte
);

    logic uart_hit_d;  // guards against a held hit

    assign irq_led = |interrupt_vector;

    // keyboard data register sampled every cycle
    always_ff @(posedge CLOCK_50) begin
        key_byte <= key_ascii;
        if (uart_hit)
            uart_data <= write_data[7:0];  // low byte only
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            interrupt_vector <= 4'd0;
            uart_hit_d       <= 1'b0;
            uart_write       <= 1'b0;
        end else begin
            // key interrupt where ack wins over a new set
            if (key_pressed && key_ascii != 8'd0)
                interrupt_vector <= 4'd1;
            if (interrupt_vector != 4'd0 && interrupt_ack)
                interrupt_vector <= 4'd0;

            uart_hit_d <= uart_hit;
            uart_write <= uart_hit && !uart_hit_d;  // rising edge only
        end
    end

    // uart hit from the fabric is a single cycle strobe
    a_uart_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_hit |=> !uart_hit);

endmodule

// File: sd_sector_buffer.sv
`timescale 1ns/1ps

module sd_sector_buffer import soc_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic [7:0]  sd_dout,
    input  logic        sd_byte_available,
    input  logic        sd_ready,
    input  logic        addr_write,
    input  logic        read_trigger,
    input  logic [31:0] write_data,
    input  logic [8:0]  cache_index,
    output logic [31:0] sd_addr,
    output logic        sd_rd_start,
    output logic        sd_cache_available,
    output logic [7:0]  cache_byte,
    output logic        ready_bit
);

    logic [7:0] cache [sector_bytes];
    logic [9:0] byte_index;      // next capture slot 0..512
    logic       byte_avail_d;    // last byte strobe for edge detect
    logic       byte_rise;

    assign byte_rise  = sd_byte_available && !byte_avail_d;
    assign cache_byte = cache[cache_index];  // async read of sector

    // capture control
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            byte_avail_d       <= 1'b0;
            byte_index         <= '0;
            sd_cache_available <= 1'b0;
        end else begin
            byte_avail_d <= sd_byte_available;
            if (byte_index == 10'(sector_bytes)) begin
                byte_index         <= '0;    // sector complete
                sd_cache_available <= 1'b1;
            end else begin
                if (byte_rise)
                    byte_index <= byte_index + 1'b1;
                if (byte_index == 10'd10)
                    sd_cache_available <= 1'b0;  // new sector under way
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (byte_rise && byte_index != 10'(sector_bytes))
            cache[byte_index[8:0]] <= sd_dout;
    end

    // controller registers
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sd_addr     <= '0;
            sd_rd_start <= 1'b0;
            ready_bit   <= 1'b0;
        end else begin
            sd_rd_start <= read_trigger;  // one cycle after the strobe
            ready_bit   <= sd_ready;      // status flop
            if (addr_write)
                sd_addr <= write_data;    // sector number
        end
    end

    // no byte strobe lands in the wrap cycle at 512
    a_index_range: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        byte_index == 10'(sector_bytes) |-> !byte_rise);

endmodule

// File: ram_port.sv
`timescale 1ns/1ps

module ram_port import soc_pkg::*; #(
    parameter int ram_words = 1024
) (
    input  logic                         CLOCK_50,
    input  logic                         KEY0,
    input  logic                         read_start,
    input  logic                         write_start,
    input  load_e                        load_type,
    input  store_e                       store_type,
    input  logic [$clog2(ram_words)-1:0] ram_index,
    input  logic [1:0]                   byte_offset,
    input  logic [xlen-1:0]              write_data,
    output logic [xlen-1:0]              read_data,
    output logic                         finish
);

    localparam int idx_w = $clog2(ram_words);

    typedef enum logic [1:0] {
        idle,
        second_load,   // upper word of ld
        second_store   // upper word of sd
    } beat_e;

    word_t             mem [ram_words];
    beat_e             beat;
    logic [idx_w-1:0]  next_index;  // word after the addressed one

    // beat sequencing
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat   <= idle;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;  // one cycle pulse
            case (beat)
                idle: begin
                    if (read_start) begin
                        if (load_type == ld) beat <= second_load;
                        else                 finish <= 1'b1;
                    end else if (write_start) begin
                        if (store_type == sd) beat <= second_store;
                        else                  finish <= 1'b1;
                    end
                end
                second_load, second_store: begin
                    beat   <= idle;
                    finish <= 1'b1;  // done after the high word
                end
                default: beat <= idle;
            endcase
        end
    end

    // word array and read data
    always_ff @(posedge CLOCK_50) begin
        if (beat == idle)
            next_index <= ram_index + 1'b1;  // wraps at top of window

        if (beat == idle && read_start) begin
            if (load_type == ld)
                read_data <= {32'd0, mem[ram_index]};  // low word first
            else
                read_data <= {32'd0, mem[ram_index] >> (8 * byte_offset)};
        end else if (beat == second_load) begin
            read_data[xlen-1:32] <= mem[next_index];
        end

        if (beat == idle && write_start) begin
            case (store_type)
                sb: mem[ram_index][8 * byte_offset +: 8] <= write_data[7:0];
                sh: mem[ram_index][16 * byte_offset[1] +: 16] <= write_data[15:0];
                sw, sd: mem[ram_index] <= write_data[31:0];
                default: ;  // no store
            endcase
        end else if (beat == second_store) begin
            mem[next_index] <= write_data[xlen-1:32];
        end
    end

    // cpu never issues code 7
    a_load_type: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        read_start |-> 3'(load_type) != 3'd7);

    // half stores sit on a half-word lane, bytes go anywhere
    a_store_align: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (write_start && store_type == sh) |-> !byte_offset[0]);

endmodule

// File: bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder import soc_pkg::*; #(
    parameter logic [xlen-1:0] ram_base       = 64'h0000_1000,
    parameter int              ram_words      = 1024,
    parameter logic [xlen-1:0] key_addr       = 64'h1000_0000,
    parameter logic [xlen-1:0] uart_addr      = 64'h1000_0008,
    parameter logic [xlen-1:0] sdc_addr_reg   = 64'h1000_0010,
    parameter logic [xlen-1:0] sdc_read_reg   = 64'h1000_0018,
    parameter logic [xlen-1:0] sdc_ready_reg  = 64'h1000_0020,
    parameter logic [xlen-1:0] sdc_avail_reg  = 64'h1000_0028,
    parameter logic [xlen-1:0] sdc_cache_base = 64'h1000_1000
) (
    input  logic [xlen-1:0]              bus_address,
    output target_e                      target,
    output logic [$clog2(ram_words)-1:0] ram_index,
    output logic [1:0]                   byte_offset,
    output logic [8:0]                   cache_index
);

    localparam int idx_w = $clog2(ram_words);

    logic [xlen-1:0] ram_offset;    // byte offset inside ram window
    logic [xlen-1:0] cache_offset;  // byte offset inside sector window

    assign ram_offset   = bus_address - ram_base;
    assign cache_offset = bus_address - sdc_cache_base;
    assign ram_index    = ram_offset[idx_w+1:2];
    assign byte_offset  = bus_address[1:0];  // lane within the word
    assign cache_index  = cache_offset[8:0];

    // priority order, ram window first
    always_comb begin
        if (bus_address >= ram_base && bus_address < ram_base + 4 * ram_words)
            target = t_ram;
        else if (bus_address == key_addr)      target = t_key;
        else if (bus_address == uart_addr)     target = t_uart;
        else if (bus_address == sdc_addr_reg)  target = t_sdc_addr;
        else if (bus_address == sdc_read_reg)  target = t_sdc_read;
        else if (bus_address == sdc_ready_reg) target = t_sdc_ready;
        else if (bus_address == sdc_avail_reg) target = t_sdc_avail;
        else if (bus_address >= sdc_cache_base &&
                 bus_address < sdc_cache_base + sector_bytes)
            target = t_sdc_cache;
        else
            target = t_none;  // nothing mapped here
    end

endmodule

// File: soc_pkg.sv
package soc_pkg;

    // bus data and address width
    localparam int xlen = 64;

    // bytes in one sd sector
    localparam int sector_bytes = 512;

    // one ram word, 4 byte lanes
    typedef logic [31:0] word_t;

    // load type as the cpu encodes it, bit 2 = unsigned
    typedef enum logic [2:0] {
        lb  = 3'd0,
        lh  = 3'd1,
        lw  = 3'd2,
        ld  = 3'd3,  // two beats
        lbu = 3'd4,
        lhu = 3'd5,
        lwu = 3'd6   // code 7 never issued
    } load_e;

    typedef enum logic [2:0] {
        sb = 3'd0,
        sh = 3'd1,
        sw = 3'd2,
        sd = 3'd3    // two beats
    } store_e;

    // decoded bus target
    typedef enum logic [3:0] {
        t_none,      // unmapped, reads zero
        t_ram,
        t_key,
        t_uart,
        t_sdc_addr,
        t_sdc_read,
        t_sdc_ready,
        t_sdc_avail,
        t_sdc_cache
    } target_e;

endpackage
